//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath widths
`define XLEN         32
`define REG_ADDR_W   5
`define CSR_ADDR_W   12

// data RAM size in words (2**DMEM_ADDR_W)
`define DMEM_ADDR_W  8

// ==================================================
// machine CSR addresses
// ==================================================
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

`endif

//--- rv_isa_pkg.sv
package rv_isa_pkg;

    // ==================================================
    // RV32I major opcodes, bits [6:0] of the instruction
    // ==================================================
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011   // csr instructions live here
    } opcode_e;

    // ==================================================
    // funct3 of loads and stores
    // ==================================================
    typedef enum logic [2:0] {
        MW_B  = 3'b000,   // byte, sign extended on load
        MW_H  = 3'b001,   // halfword, sign extended on load
        MW_W  = 3'b010,
        MW_BU = 3'b100,   // load only
        MW_HU = 3'b101    // load only
    } mem_width_e;

endpackage

//--- rv_pipe_pkg.sv
`include "rv_defs.svh"

package rv_pipe_pkg;

    typedef logic [`XLEN-1:0]   xword_t;
    typedef logic [`XLEN/8-1:0] byte_en_t;   // one bit per byte lane

    // load unit: one wait cycle for the synchronous RAM read
    typedef enum logic {
        LSU_IDLE      = 1'b0,
        LSU_LOAD_WAIT = 1'b1
    } lsu_state_e;

    // source of the register write data
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2,
        WB_CSR = 2'd3
    } wb_src_e;

endpackage

//--- ex_mem_regs.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module ex_mem_regs import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   interlock,

    input  xword_t                 pc4_in,
    output xword_t                 pc4_out,

    input  xword_t                 b_in,
    output xword_t                 b_out,

    input  xword_t                 c_in,
    output xword_t                 c_out,

    input  xword_t                 z_in,
    output xword_t                 z_out,

    input  mem_width_e             funct3_in,
    output mem_width_e             funct3_out,

    input  logic [`REG_ADDR_W-1:0] rd_in,
    output logic [`REG_ADDR_W-1:0] rd_out,

    input  logic [`CSR_ADDR_W-1:0] csr_addr_in,
    output logic [`CSR_ADDR_W-1:0] csr_addr_out,

    input  opcode_e                opcode_in,
    output opcode_e                opcode_out,

    input  logic                   wr_reg_n_in,
    output logic                   wr_reg_n_out,

    input  logic                   wr_csr_n_in,
    output logic                   wr_csr_n_out,

    input  logic                   flush_in,
    output logic                   flush_out
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc4_out      <= 'x;
            b_out        <= 'x;
            c_out        <= 'x;
            z_out        <= 'x;
            funct3_out   <= mem_width_e'(3'bx);
            rd_out       <= 'x;
            csr_addr_out <= 'x;
            opcode_out   <= opcode_e'(7'bx);
            wr_reg_n_out <= 1'b1;   // no register write
            wr_csr_n_out <= 1'b1;   // no csr write
            flush_out    <= 1'b0;
        end else if (!interlock) begin
            pc4_out      <= pc4_in;
            b_out        <= b_in;
            c_out        <= c_in;
            z_out        <= z_in;
            funct3_out   <= funct3_in;
            rd_out       <= rd_in;
            csr_addr_out <= csr_addr_in;
            opcode_out   <= opcode_in;
            wr_reg_n_out <= wr_reg_n_in;
            wr_csr_n_out <= wr_csr_n_in;
            flush_out    <= flush_in;
        end
        // interlock high: every field holds
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_stage import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  xword_t                  pc4,
    input  xword_t                  b,
    input  xword_t                  c,
    input  xword_t                  z,
    input  mem_width_e              funct3,
    input  logic [`REG_ADDR_W-1:0]  rd,
    input  logic [`CSR_ADDR_W-1:0]  csr_addr,
    input  opcode_e                 opcode,
    input  logic                    wr_reg_n,
    input  logic                    wr_csr_n,
    input  logic                    flush,
    input  xword_t                  ram_rdata,
    input  xword_t                  csr_rdata,
    output logic                    stall,
    output logic [`DMEM_ADDR_W-1:0] ram_addr,
    output byte_en_t                ram_be,
    output xword_t                  ram_wdata,
    output logic                    ram_we,
    output logic [`CSR_ADDR_W-1:0]  csr_addr_o,
    output logic                    csr_we,
    output xword_t                  csr_wdata,
    output logic                    wb_wr_n,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output xword_t                  wb_wdata
);

    logic       is_load;
    logic       is_store;
    logic [1:0] offset;     // byte offset in the word truncated to the access size
    byte_en_t   be_base;
    xword_t     st_data;
    xword_t     ld_shift;
    xword_t     ld_data;
    wb_src_e    wb_src;
    lsu_state_e state;
    lsu_state_e state_nxt;

    // an unknown opcode out of reset decodes as neither
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (opcode)
            OPC_LOAD:  is_load  = 1'b1;
            OPC_STORE: is_store = 1'b1;
            default:   ;
        endcase
    end

    // ==================================================
    // alignment
    // ==================================================
    always_comb begin
        case (funct3)
            MW_B, MW_BU: begin
                offset  = z[1:0];
                be_base = 4'b0001;
                st_data = {{(`XLEN-8){1'b0}}, b[7:0]};
            end
            MW_H, MW_HU: begin
                offset  = {z[1], 1'b0};
                be_base = 4'b0011;
                st_data = {{(`XLEN-16){1'b0}}, b[15:0]};
            end
            default: begin
                offset  = 2'b00;
                be_base = 4'b1111;
                st_data = b;
            end
        endcase
    end

    assign ram_addr  = z[`DMEM_ADDR_W+1:2];
    assign ram_be    = be_base << offset;
    assign ram_wdata = st_data << {offset, 3'b000};
    assign ram_we    = is_store && !flush;

    // load moves the addressed lane down and extends it
    assign ld_shift = ram_rdata >> {offset, 3'b000};

    always_comb begin
        case (funct3)
            MW_B:    ld_data = {{(`XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
            MW_BU:   ld_data = {{(`XLEN-8){1'b0}}, ld_shift[7:0]};
            MW_H:    ld_data = {{(`XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
            MW_HU:   ld_data = {{(`XLEN-16){1'b0}}, ld_shift[15:0]};
            default: ld_data = ld_shift;
        endcase
    end

    // ==================================================
    // load FSM
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LSU_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LSU_IDLE:      if (is_load && !flush) state_nxt = LSU_LOAD_WAIT;
            LSU_LOAD_WAIT: state_nxt = LSU_IDLE;   // ram data valid this cycle
            default:       state_nxt = LSU_IDLE;
        endcase
    end

    assign stall = (state == LSU_IDLE) && is_load && !flush;

    // csr access with the old value going to rd
    assign csr_addr_o = csr_addr;
    assign csr_we     = !wr_csr_n && !flush;
    assign csr_wdata  = c;

    // ==================================================
    // writeback
    // ==================================================
    always_comb begin
        case (opcode)
            OPC_LOAD:          wb_src = WB_MEM;
            OPC_JAL, OPC_JALR: wb_src = WB_PC4;
            OPC_SYSTEM:        wb_src = WB_CSR;
            default:           wb_src = WB_ALU;
        endcase
    end

    always_comb begin
        case (wb_src)
            WB_MEM:  wb_wdata = ld_data;
            WB_PC4:  wb_wdata = pc4;
            WB_CSR:  wb_wdata = csr_rdata;
            default: wb_wdata = z;
        endcase
    end

    assign wb_wr_n = wr_reg_n || flush || stall;   // bubble while the load waits
    assign wb_rd   = rd;

endmodule

//--- data_ram.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module data_ram import rv_pipe_pkg::*; #(
    parameter int ADDR_W = `DMEM_ADDR_W
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    input  byte_en_t          be,
    input  xword_t            wdata,
    input  logic              we,
    output xword_t            rdata
);

    xword_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        rdata <= mem[addr];   // old data on a same-cycle write
    end

endmodule

//--- csr_regs.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module csr_regs import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CSR_ADDR_W-1:0] addr,
    input  logic                   we,
    input  xword_t                 wdata,
    output xword_t                 rdata
);

    xword_t mscratch;
    xword_t mtvec;
    xword_t mepc;
    xword_t mcause;

    always_comb begin
        case (addr)
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MTVEC:    rdata = mtvec;
            `CSR_MEPC:     rdata = mepc;
            `CSR_MCAUSE:   rdata = mcause;
            default:       rdata = '0;   // unimplemented csr
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mscratch <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (we) begin
            case (addr)
                `CSR_MSCRATCH: mscratch <= wdata;
                `CSR_MTVEC:    mtvec    <= wdata;
                `CSR_MEPC:     mepc     <= wdata;
                `CSR_MCAUSE:   mcause   <= wdata;
                default:       ;
            endcase
        end
    end

endmodule

//--- mem_wb_regs.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module mem_wb_regs import rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   wr_reg_n_in,
    output logic                   wr_reg_n_out,

    input  logic [`REG_ADDR_W-1:0] rd_in,
    output logic [`REG_ADDR_W-1:0] rd_out,

    input  xword_t                 wdata_in,
    output xword_t                 wdata_out
);

    // writes to x0 go through, the register file drops them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_reg_n_out <= 1'b1;
            rd_out       <= 'x;
            wdata_out    <= 'x;
        end else begin
            wr_reg_n_out <= wr_reg_n_in;
            rd_out       <= rd_in;
            wdata_out    <= wdata_in;
        end
    end

endmodule

//--- ex_mem_wb.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module ex_mem_wb import rv_isa_pkg::*, rv_pipe_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  xword_t                 pc4,
    input  xword_t                 b,
    input  xword_t                 c,
    input  xword_t                 z,
    input  mem_width_e             funct3,
    input  logic [`REG_ADDR_W-1:0] rd,
    input  logic [`CSR_ADDR_W-1:0] csr_addr,
    input  opcode_e                opcode,
    input  logic                   wr_reg_n,
    input  logic                   wr_csr_n,
    input  logic                   flush,
    output logic                   rf_wr_n,
    output logic [`REG_ADDR_W-1:0] rf_rd,
    output xword_t                 rf_wdata,
    output logic                   stall
);

    // ==================================================
    // EX/MEM register outputs
    // ==================================================
    xword_t                 m_pc4;
    xword_t                 m_b;
    xword_t                 m_c;
    xword_t                 m_z;
    mem_width_e             m_funct3;
    logic [`REG_ADDR_W-1:0] m_rd;
    logic [`CSR_ADDR_W-1:0] m_csr_addr;
    opcode_e                m_opcode;
    logic                   m_wr_reg_n;
    logic                   m_wr_csr_n;
    logic                   m_flush;

    // ram and csr ports
    logic [`DMEM_ADDR_W-1:0] ram_addr;
    byte_en_t                ram_be;
    xword_t                  ram_wdata;
    xword_t                  ram_rdata;
    logic                    ram_we;
    logic [`CSR_ADDR_W-1:0]  csr_addr_m;
    logic                    csr_we;
    xword_t                  csr_wdata;
    xword_t                  csr_rdata;

    // MEM/WB inputs
    logic                   wb_wr_n;
    logic [`REG_ADDR_W-1:0] wb_rd;
    xword_t                 wb_wdata;

    ex_mem_regs u_ex_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .interlock    (stall),
        .pc4_in       (pc4),         .pc4_out      (m_pc4),
        .b_in         (b),           .b_out        (m_b),
        .c_in         (c),           .c_out        (m_c),
        .z_in         (z),           .z_out        (m_z),
        .funct3_in    (funct3),      .funct3_out   (m_funct3),
        .rd_in        (rd),          .rd_out       (m_rd),
        .csr_addr_in  (csr_addr),    .csr_addr_out (m_csr_addr),
        .opcode_in    (opcode),      .opcode_out   (m_opcode),
        .wr_reg_n_in  (wr_reg_n),    .wr_reg_n_out (m_wr_reg_n),
        .wr_csr_n_in  (wr_csr_n),    .wr_csr_n_out (m_wr_csr_n),
        .flush_in     (flush),       .flush_out    (m_flush)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc4        (m_pc4),
        .b          (m_b),
        .c          (m_c),
        .z          (m_z),
        .funct3     (m_funct3),
        .rd         (m_rd),
        .csr_addr   (m_csr_addr),
        .opcode     (m_opcode),
        .wr_reg_n   (m_wr_reg_n),
        .wr_csr_n   (m_wr_csr_n),
        .flush      (m_flush),
        .ram_rdata  (ram_rdata),
        .csr_rdata  (csr_rdata),
        .stall      (stall),
        .ram_addr   (ram_addr),
        .ram_be     (ram_be),
        .ram_wdata  (ram_wdata),
        .ram_we     (ram_we),
        .csr_addr_o (csr_addr_m),
        .csr_we     (csr_we),
        .csr_wdata  (csr_wdata),
        .wb_wr_n    (wb_wr_n),
        .wb_rd      (wb_rd),
        .wb_wdata   (wb_wdata)
    );

    data_ram #(.ADDR_W(`DMEM_ADDR_W)) u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .be    (ram_be),
        .wdata (ram_wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    csr_regs u_csr (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (csr_addr_m),
        .we    (csr_we),
        .wdata (csr_wdata),
        .rdata (csr_rdata)
    );

    mem_wb_regs u_mem_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_reg_n_in  (wb_wr_n),     .wr_reg_n_out (rf_wr_n),
        .rd_in        (wb_rd),       .rd_out       (rf_rd),
        .wdata_in     (wb_wdata),    .wdata_out    (rf_wdata)
    );

endmodule

//--- tb_ex_mem_wb.sv
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_ex_mem_wb import rv_isa_pkg::*, rv_pipe_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int N_ALU       = 8;
    localparam int N_MEM       = 4 + 8 + 20;   // word fills, sub-word stores, loads
    localparam int N_CSR       = 14;
    localparam int N_FLUSH     = 8;
    localparam int N_INSTR     = N_ALU + N_MEM + N_CSR + N_FLUSH;
    localparam int TIMEOUT_CYC = N_INSTR * 4 + 40;

    logic                   clk = 1'b0;
    logic                   rst_n;
    xword_t                 pc4;
    xword_t                 b;
    xword_t                 c;
    xword_t                 z;
    mem_width_e             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    opcode_e                opcode;
    logic                   wr_reg_n;
    logic                   wr_csr_n;
    logic                   flush;
    logic                   rf_wr_n;
    logic [`REG_ADDR_W-1:0] rf_rd;
    xword_t                 rf_wdata;
    logic                   stall;

    // reference model state
    xword_t                 model_mem [2**`DMEM_ADDR_W];
    xword_t                 model_csr [4];
    logic [15:0]            lfsr = 16'd84;
    int                     cyc = 0;      // posedges seen so far
    logic                   mon_on = 1'b0;
    string                  cur_test = "reset";

    // expected writebacks keyed by the cycle they show up on rf_*
    int                     exp_due [$];
    logic [`REG_ADDR_W-1:0] exp_rd [$];
    xword_t                 exp_data [$];
    int                     stall_due [$];

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ex_mem_wb u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc4      (pc4),
        .b        (b),
        .c        (c),
        .z        (z),
        .funct3   (funct3),
        .rd       (rd),
        .csr_addr (csr_addr),
        .opcode   (opcode),
        .wr_reg_n (wr_reg_n),
        .wr_csr_n (wr_csr_n),
        .flush    (flush),
        .rf_wr_n  (rf_wr_n),
        .rf_rd    (rf_rd),
        .rf_wdata (rf_wdata),
        .stall    (stall)
    );

    // ==================================================
    // helpers
    // ==================================================
    task automatic check(input string what, input xword_t expected, input xword_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", what, expected, actual);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic xword_t next_bits(input int n);
        xword_t r;
        logic   fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[`XLEN-2:0], fb};
        end
        return r;
    endfunction

    function automatic logic [`REG_ADDR_W-1:0] next_rd();
        xword_t t;
        t = next_bits(`REG_ADDR_W);
        return t[`REG_ADDR_W-1:0];
    endfunction

    // stores rotate through B, H and W
    function automatic mem_width_e store_width(input int i);
        case (i % 3)
            0:       return MW_B;
            1:       return MW_H;
            default: return MW_W;
        endcase
    endfunction

    // loads rotate through all five widths
    function automatic mem_width_e load_width(input int i);
        case (i % 5)
            0:       return MW_B;
            1:       return MW_H;
            2:       return MW_W;
            3:       return MW_BU;
            default: return MW_HU;
        endcase
    endfunction

    function automatic int csr_index(input logic [`CSR_ADDR_W-1:0] a);
        case (a)
            `CSR_MSCRATCH: return 0;
            `CSR_MTVEC:    return 1;
            `CSR_MEPC:     return 2;
            `CSR_MCAUSE:   return 3;
            default:       return -1;   // not implemented
        endcase
    endfunction

    // low address bits below the access size are ignored
    function automatic xword_t model_load(input mem_width_e w, input xword_t addr);
        xword_t      word;
        logic [7:0]  by;
        logic [15:0] hw;
        word = model_mem[addr[`DMEM_ADDR_W+1:2]];
        by   = word[8*addr[1:0] +: 8];
        hw   = word[16*addr[1] +: 16];
        case (w)
            MW_B:    return {{24{by[7]}}, by};
            MW_BU:   return {24'b0, by};
            MW_H:    return {{16{hw[15]}}, hw};
            MW_HU:   return {16'b0, hw};
            default: return word;
        endcase
    endfunction

    function automatic void model_store(input mem_width_e w, input xword_t addr,
                                        input xword_t data);
        logic [`DMEM_ADDR_W-1:0] wa;
        wa = addr[`DMEM_ADDR_W+1:2];
        case (w)
            MW_B:    model_mem[wa][8*addr[1:0] +: 8] = data[7:0];
            MW_H:    model_mem[wa][16*addr[1] +: 16] = data[15:0];
            default: model_mem[wa] = data;
        endcase
    endfunction

    task automatic drive_nop();
        pc4      = '0;
        b        = '0;
        c        = '0;
        z        = '0;
        funct3   = MW_W;
        rd       = '0;
        csr_addr = '0;
        opcode   = OPC_OP;
        wr_reg_n = 1'b1;
        wr_csr_n = 1'b1;
        flush    = 1'b0;
    endtask

    // called on a falling edge and returns on the falling edge after capture
    task automatic send(input opcode_e op, input mem_width_e f3, input xword_t z_v,
                        input xword_t b_v, input xword_t c_v,
                        input logic [`REG_ADDR_W-1:0] dst,
                        input logic [`CSR_ADDR_W-1:0] ca,
                        input logic reg_n, input logic csr_n, input logic fl);
        wb_src_e src;
        xword_t  p;
        xword_t  expd;
        int      ci;
        int      waited;
        p        = next_bits(32);
        pc4      = p;
        b        = b_v;
        c        = c_v;
        z        = z_v;
        funct3   = f3;
        rd       = dst;
        csr_addr = ca;
        opcode   = op;
        wr_reg_n = reg_n;
        wr_csr_n = csr_n;
        flush    = fl;
        waited   = 0;
        while (stall) begin   // held until the interlock drops
            @(negedge clk);
            waited++;
            if (waited > 4) begin
                $display("stall stayed high for more than 4 cycles in test %s", cur_test);
                $display("** FAIL **");
                $fatal(1, "interlock never released");
            end
        end
        case (op)
            OPC_LOAD:          src = WB_MEM;
            OPC_JAL, OPC_JALR: src = WB_PC4;
            OPC_SYSTEM:        src = WB_CSR;
            default:           src = WB_ALU;
        endcase
        ci = csr_index(ca);
        case (src)
            WB_MEM:  expd = model_load(f3, z_v);
            WB_PC4:  expd = p;
            WB_CSR:  expd = (ci < 0) ? '0 : model_csr[ci];   // old value
            default: expd = z_v;
        endcase
        // capture edge is cyc+1
        if (!reg_n && !fl) begin
            exp_due.push_back((op == OPC_LOAD) ? cyc + 3 : cyc + 2);
            exp_rd.push_back(dst);
            exp_data.push_back(expd);
        end
        if (op == OPC_LOAD && !fl)
            stall_due.push_back(cyc + 1);
        if (op == OPC_STORE && !fl)
            model_store(f3, z_v, b_v);
        if (!csr_n && !fl && ci >= 0)
            model_csr[ci] = c_v;
        @(negedge clk);
        drive_nop();
    endtask

    task automatic drain();
        while (exp_due.size() > 0 || stall_due.size() > 0)
            @(negedge clk);
    endtask

    // ==================================================
    // writeback and stall monitor
    // ==================================================
    always @(negedge clk) begin
        logic exp_stall;
        if (mon_on) begin
            if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                check({cur_test, " rf_wr_n"}, 32'd0, {31'b0, rf_wr_n});
                check({cur_test, " rf_rd"}, {{(`XLEN-`REG_ADDR_W){1'b0}}, exp_rd[0]},
                      {{(`XLEN-`REG_ADDR_W){1'b0}}, rf_rd});
                check({cur_test, " rf_wdata"}, exp_data[0], rf_wdata);
                exp_due.delete(0);
                exp_rd.delete(0);
                exp_data.delete(0);
            end else begin
                check({cur_test, " rf_wr_n"}, 32'd1, {31'b0, rf_wr_n});   // no stray write
            end
            exp_stall = (stall_due.size() > 0 && stall_due[0] == cyc);
            if (exp_stall)
                stall_due.delete(0);
            check({cur_test, " stall"}, {31'b0, exp_stall}, {31'b0, stall});
        end
    end

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset();
        cur_test = "reset";
        check({cur_test, " rf_wr_n"}, 32'd1, {31'b0, rf_wr_n});
        check({cur_test, " stall"}, 32'd0, {31'b0, stall});
    endtask

    task automatic test_alu();
        opcode_e op;
        xword_t  v;
        logic    reg_n;
        cur_test = "alu_jump";
        for (int i = 0; i < N_ALU; i++) begin
            v     = next_bits(32);
            reg_n = (i == 5);   // one without a register write
            case (i % 4)
                0:       op = OPC_OP_IMM;
                1:       op = OPC_JAL;
                2:       op = OPC_OP;
                default: op = OPC_JALR;
            endcase
            send(op, MW_W, v, '0, '0, next_rd(), 12'h0, reg_n, 1'b1, 1'b0);
        end
    endtask

    task automatic test_mem();
        xword_t     base [4];
        xword_t     t;
        xword_t     v;
        mem_width_e w;
        cur_test = "store_load";
        for (int i = 0; i < 4; i++) begin
            t       = next_bits(8);
            base[i] = {22'b0, t[7:0], 2'b00};
            v       = next_bits(32);
            send(OPC_STORE, MW_W, base[i], v, '0, 5'd0, 12'h0, 1'b1, 1'b1, 1'b0);
        end
        for (int i = 0; i < 8; i++) begin
            t = next_bits(4);
            w = store_width(i);
            v = next_bits(32);
            send(OPC_STORE, w, base[t[3:2]] | {30'b0, t[1:0]}, v, '0, 5'd0, 12'h0,
                 1'b1, 1'b1, 1'b0);
        end
        // back-to-back loads where each one waits at the inputs during the previous stall
        for (int i = 0; i < 20; i++) begin
            t = next_bits(4);
            w = load_width(i);
            send(OPC_LOAD, w, base[t[3:2]] | {30'b0, t[1:0]}, '0, '0, next_rd(), 12'h0,
                 1'b0, 1'b1, 1'b0);
        end
    endtask

    task automatic test_csr();
        logic [`CSR_ADDR_W-1:0] csr_list [4];
        xword_t                 v;
        cur_test = "csr";
        csr_list = '{`CSR_MSCRATCH, `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE};
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 4; i++) begin
                v = next_bits(32);
                // funct3 001 is csrrw
                send(OPC_SYSTEM, MW_H, '0, '0, v, next_rd(), csr_list[i], 1'b0, 1'b0, 1'b0);
            end
        end
        for (int i = 0; i < 4; i++)
            send(OPC_SYSTEM, MW_H, '0, '0, '0, next_rd(), csr_list[i], 1'b0, 1'b1, 1'b0);
        v = next_bits(32);
        send(OPC_SYSTEM, MW_H, '0, '0, v, 5'd9, 12'h7c0, 1'b0, 1'b0, 1'b0);
        send(OPC_SYSTEM, MW_H, '0, '0, '0, 5'd10, 12'h7c0, 1'b0, 1'b1, 1'b0);
    endtask

    task automatic test_flush();
        xword_t t;
        xword_t a;
        xword_t v;
        cur_test = "flush";
        t = next_bits(8);
        a = {22'b0, t[7:0], 2'b00};
        v = next_bits(32);
        send(OPC_STORE, MW_W, a, v, '0, 5'd0, 12'h0, 1'b1, 1'b1, 1'b0);
        v = next_bits(32);
        send(OPC_STORE, MW_B, a + 1, v, '0, 5'd0, 12'h0, 1'b1, 1'b1, 1'b1);
        send(OPC_LOAD, MW_W, a, '0, '0, 5'd3, 12'h0, 1'b0, 1'b1, 1'b0);   // old word
        send(OPC_SYSTEM, MW_H, '0, '0, v, 5'd4, `CSR_MSCRATCH, 1'b0, 1'b0, 1'b1);
        send(OPC_SYSTEM, MW_H, '0, '0, '0, 5'd5, `CSR_MSCRATCH, 1'b0, 1'b1, 1'b0);
        send(OPC_OP_IMM, MW_W, v, '0, '0, 5'd6, 12'h0, 1'b0, 1'b1, 1'b1);
        send(OPC_LOAD, MW_W, a, '0, '0, 5'd7, 12'h0, 1'b0, 1'b1, 1'b1);   // no stall
        send(OPC_JAL, MW_W, v, '0, '0, 5'd8, 12'h0, 1'b0, 1'b1, 1'b1);
    endtask

    // ==================================================
    // main sequence and watchdog
    // ==================================================
    initial begin
        drive_nop();
        for (int i = 0; i < 4; i++)
            model_csr[i] = '0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        mon_on = 1'b1;
        test_alu();
        drain();
        test_mem();
        drain();
        test_csr();
        drain();
        test_flush();
        drain();
        $display("** PASS **");
        $finish;
    end

    initial begin
        #(TIMEOUT_CYC * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- all.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
ex_mem_regs.sv
mem_stage.sv
data_ram.sv
csr_regs.sv
mem_wb_regs.sv
ex_mem_wb.sv
tb_ex_mem_wb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0 --x-assign 0 --x-initial 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_ex_mem_wb
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
